// ==== all.f ====
tm1638_pkg.sv
byte_link_if.sv
sclk_divider.sv
display_buffer.sv
byte_shifter.sv
frame_sequencer.sv
tm1638_drv.sv
tb_tm1638_asserts.sv
tb_tm1638_drv.sv

// ==== Bender.yml ====
package:
  name: tm1638_drv

sources:
  - tm1638_pkg.sv
  - byte_link_if.sv
  - sclk_divider.sv
  - display_buffer.sv
  - byte_shifter.sv
  - frame_sequencer.sv
  - tm1638_drv.sv
  - target: test
    files:
      - tb_tm1638_asserts.sv
      - tb_tm1638_drv.sv

// ==== tb_tm1638_drv.sv ====
// ##############################################
// testbench for tm1638_drv: random display and key
// data per frame, a board model that answers key
// reads, checking done by the bound assertions
// ##############################################

`timescale 1ns/1ns

module tb_tm1638_drv;

    localparam int HALF_DIV     = 2;
    localparam int FRAME_SCLKS  = 400;
    localparam int FRAME_CYCLES = 2 * HALF_DIV * FRAME_SCLKS;
    localparam int NUM_FRAMES   = 4;
    localparam int MAX_CYCLES   = 5 * FRAME_CYCLES + FRAME_CYCLES / 2;
    localparam logic [31:0] SEED = 32'hf6ec_4bb2;

    logic        clk;
    logic        n_rst;
    logic [31:0] digits_i;
    logic [7:0]  blank_i;
    logic [7:0]  dots_i;
    logic [7:0]  leds_i;
    logic        dio_i;
    logic        dio_o;
    logic        dio_oe_o;
    logic        sclk_o;
    logic        stb_o;
    logic        frame_start_o;
    logic [7:0]  keys_o;

    logic [31:0] key_scan;      // read bits of the 4 key bytes, LSB first
    logic        stb_seen = 1'b1;
    logic        sclk_seen = 1'b1;
    logic        timed_out = 1'b0;
    int          grp_cnt = 0;
    int          fall_cnt = 0;
    int          frames_done = 0;
    int          cycle_cnt = 0;

    tm1638_drv #(
        .HALF_DIV    (HALF_DIV),
        .FRAME_SCLKS (FRAME_SCLKS)
    ) UUT (
        .clk           (clk),
        .n_rst         (n_rst),
        .digits_i      (digits_i),
        .blank_i       (blank_i),
        .dots_i        (dots_i),
        .leds_i        (leds_i),
        .dio_i         (dio_i),
        .dio_o         (dio_o),
        .dio_oe_o      (dio_oe_o),
        .sclk_o        (sclk_o),
        .stb_o         (stb_o),
        .frame_start_o (frame_start_o),
        .keys_o        (keys_o)
    );

    always #20 clk = ~clk;

    // board model: next key bit after each sclk fall of the read bytes
    always @(posedge clk) begin
        #5;
        if (frame_start_o) begin
            grp_cnt = 0;
        end
        if (!stb_o && stb_seen) begin
            fall_cnt = 0;
        end
        if (stb_o && !stb_seen) begin
            grp_cnt = grp_cnt + 1;
            if (grp_cnt == 4) begin
                frames_done = frames_done + 1;
            end
        end
        if (!stb_o && !sclk_o && sclk_seen) begin
            if (grp_cnt == 3 && fall_cnt >= 8 && fall_cnt < 40) begin
                dio_i = key_scan[fall_cnt - 8];
            end else begin
                dio_i = 1'b1;
            end
            fall_cnt = fall_cnt + 1;
        end
        if (stb_o) begin
            dio_i = 1'b1;   // pull-up
        end
        stb_seen  = stb_o;
        sclk_seen = sclk_o;
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: %0d frames not done after %0d clk cycles", NUM_FRAMES, cycle_cnt);
            timed_out = 1'b1;
            finish_run();
        end
    end

    task automatic draw_frame_inputs();
        digits_i = $urandom();
        blank_i  = 8'($urandom() & $urandom());   // about one grid in four
        dots_i   = 8'($urandom());
        leds_i   = 8'($urandom());
        key_scan = $urandom();
    endtask

    task automatic finish_run();
        int fails;
        fails = UUT.u_asserts.fail_cnt;
        $display("checks done: %0d assertion failures, %0d timeouts", fails, timed_out);
        if (fails == 0 && !timed_out) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    initial begin
        clk   = 1'b0;
        n_rst = 1'b0;
        dio_i = 1'b1;
        void'($urandom(SEED));
        draw_frame_inputs();
        repeat (2) @(posedge clk);
        #5;
        n_rst = 1'b1;
        // new data only once a frame is fully sent
        for (int f = 0; f < NUM_FRAMES; f++) begin
            do @(posedge clk); while (frames_done <= f);
            #5;
            draw_frame_inputs();
        end
        repeat (2) @(posedge clk);
        #5;
        finish_run();
    end

endmodule

// ==== tb_tm1638_asserts.sv ====
// ##############################################
// protocol checks for the TM1638 driver, bound into
// tm1638_drv. decodes the serial bytes per strobe group
// and compares them with values built from the inputs
// ##############################################

`timescale 1ns/1ns

module tb_tm1638_asserts #(
    parameter int HALF_DIV    = 2,
    parameter int FRAME_SCLKS = 400
) (
    input logic        clk,
    input logic        n_rst,
    input logic [31:0] digits_i,
    input logic [7:0]  blank_i,
    input logic [7:0]  dots_i,
    input logic [7:0]  leds_i,
    input logic        dio_i,
    input logic        dio_o,
    input logic        dio_oe_o,
    input logic        sclk_o,
    input logic        stb_o,
    input logic        frame_start_o,
    input logic [7:0]  keys_o
);

    localparam int FRAME_CYCLES = 2 * HALF_DIV * FRAME_SCLKS;
    // gfedcba per hex digit, digit 0 in the low byte
    localparam logic [127:0] SEG_ROM     = 128'h71_79_5E_39_7C_77_6F_7F_27_7D_6D_66_4F_5B_06_3F;
    localparam logic [31:0]  FIRST_BYTES = 32'h42_8F_C0_40;   // group 0 in the low byte
    localparam logic [19:0]  BYTE_COUNTS = {5'd5, 5'd1, 5'd17, 5'd1};

    int fail_cnt = 0;

    logic [31:0] digits_s;
    logic [7:0]  blank_s;
    logic [7:0]  dots_s;
    logic [7:0]  leds_s;
    logic        sclk_d;
    logic        stb_d;
    logic        dout_d;
    logic        din_d;
    logic        oe_d;
    logic [2:0]  bit_cnt;
    logic [7:0]  shreg;
    logic [7:0]  cur_byte;
    logic [7:0]  first_byte;
    logic        byte_stb;
    logic [2:0]  grp;
    logic [2:0]  byte_grp;
    logic [4:0]  byte_pos;
    logic [4:0]  byte_in_grp;
    logic [7:0]  exp_keys;
    logic [31:0] since_start;
    logic        seen_start;
    logic        bit_stb;
    logic        stb_rise;
    logic        bit_val;
    logic [3:0]  grid_idx;
    logic [3:0]  digit;
    logic [7:0]  grid_exp;
    logic [7:0]  first_exp;
    logic [4:0]  count_exp;
    logic [7:0]  next_byte;

    assign bit_stb   = sclk_o && !sclk_d && !stb_o;
    assign stb_rise  = stb_o && !stb_d;
    assign bit_val   = oe_d ? dout_d : din_d;   // bit present just before the rise
    assign next_byte = {bit_val, shreg[7:1]};
    assign grid_idx  = 4'(byte_pos - 1'b1);
    assign digit     = digits_s[grid_idx[3:1] * 4 +: 4];
    assign first_exp = FIRST_BYTES[grp * 8 +: 8];
    assign count_exp = BYTE_COUNTS[grp * 5 +: 5];

    always_comb begin
        if (grid_idx[0]) begin
            grid_exp = {7'b0, leds_s[grid_idx[3:1]]};
        end else if (blank_s[grid_idx[3:1]]) begin
            grid_exp = {dots_s[grid_idx[3:1]], 7'b0};
        end else begin
            grid_exp = {dots_s[grid_idx[3:1]], SEG_ROM[digit * 8 +: 7]};
        end
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            digits_s    <= '0;
            blank_s     <= '0;
            dots_s      <= '0;
            leds_s      <= '0;
            sclk_d      <= 1'b1;
            stb_d       <= 1'b1;
            dout_d      <= 1'b0;
            din_d       <= 1'b0;
            oe_d        <= 1'b0;
            bit_cnt     <= '0;
            shreg       <= '0;
            cur_byte    <= '0;
            first_byte  <= '0;
            byte_stb    <= 1'b0;
            grp         <= '0;
            byte_grp    <= '0;
            byte_pos    <= '0;
            byte_in_grp <= '0;
            exp_keys    <= '0;
            since_start <= '0;
            seen_start  <= 1'b0;
        end else begin
            sclk_d      <= sclk_o;
            stb_d       <= stb_o;
            dout_d      <= dio_o;
            din_d       <= dio_i;
            oe_d        <= dio_oe_o;
            byte_stb    <= 1'b0;
            since_start <= since_start + 1'b1;
            if (frame_start_o) begin   // snapshot, same as the display latch
                grp         <= '0;
                digits_s    <= digits_i;
                blank_s     <= blank_i;
                dots_s      <= dots_i;
                leds_s      <= leds_i;
                since_start <= 32'd1;
                seen_start  <= 1'b1;
            end else if (stb_rise) begin
                grp <= grp + 1'b1;
            end
            if (!stb_o && stb_d) begin
                bit_cnt     <= '0;
                byte_in_grp <= '0;
            end else if (bit_stb) begin
                shreg   <= next_byte;
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == 3'd7) begin
                    cur_byte    <= next_byte;
                    byte_stb    <= 1'b1;
                    byte_grp    <= grp;
                    byte_pos    <= byte_in_grp;
                    byte_in_grp <= byte_in_grp + 1'b1;
                    if (byte_in_grp == 5'd0) begin
                        first_byte <= next_byte;
                    end
                    if (grp == 3'd3 && byte_in_grp != 5'd0) begin   // key byte k = pos - 1
                        exp_keys[9 - 2 * byte_in_grp] <= next_byte[0];
                        exp_keys[8 - 2 * byte_in_grp] <= next_byte[4];
                    end
                end
            end
        end
    end

    a_reset_state: assert property (@(posedge clk)
        $rose(n_rst) |-> stb_o && sclk_o && !dio_oe_o && keys_o == 8'h00)
        else begin
            fail_cnt++;
            $error("ERROR after reset: stb_o=%h sclk_o=%h dio_oe_o=%h keys_o=%h",
                $sampled(stb_o), $sampled(sclk_o), $sampled(dio_oe_o), $sampled(keys_o));
        end

    a_sclk_in_group: assert property (@(posedge clk) disable iff (!n_rst)
        sclk_o != sclk_d |-> !stb_o)
        else begin
            fail_cnt++;
            $error("sclk_o toggled while stb_o was high");
        end

    a_group_bytes: assert property (@(posedge clk) disable iff (!n_rst)
        stb_rise |-> grp < 3'd4 && first_byte == first_exp && byte_in_grp == count_exp)
        else begin
            fail_cnt++;
            $error("ERROR strobe group %0d: first_byte=%h expected %h, byte count=%h expected %h",
                $sampled(grp), $sampled(first_byte), $sampled(first_exp),
                $sampled(byte_in_grp), $sampled(count_exp));
        end

    a_grid_byte: assert property (@(posedge clk) disable iff (!n_rst)
        byte_stb && byte_grp == 3'd1 && byte_pos != 5'd0 |-> cur_byte == grid_exp)
        else begin
            fail_cnt++;
            $error("ERROR grid byte %h: cur_byte=%h expected %h",
                $sampled(grid_idx), $sampled(cur_byte), $sampled(grid_exp));
        end

    a_dio_dir: assert property (@(posedge clk) disable iff (!n_rst)
        bit_stb |-> oe_d == !(grp == 3'd3 && byte_in_grp != 5'd0))
        else begin
            fail_cnt++;
            $error("ERROR dio_oe_o=%h in group %0d byte %0d", $sampled(oe_d),
                $sampled(grp), $sampled(byte_in_grp));
        end

    a_keys: assert property (@(posedge clk) disable iff (!n_rst)
        stb_rise && grp == 3'd3 |-> keys_o == exp_keys)
        else begin
            fail_cnt++;
            $error("ERROR keys_o=%h expected %h", $sampled(keys_o), $sampled(exp_keys));
        end

    a_frame_period: assert property (@(posedge clk) disable iff (!n_rst)
        frame_start_o && seen_start |-> since_start == FRAME_CYCLES && grp == 3'd4)
        else begin
            fail_cnt++;
            $error("ERROR frame_start_o spacing=%h expected %h, groups done=%h",
                $sampled(since_start), FRAME_CYCLES, $sampled(grp));
        end

endmodule

bind tm1638_drv tb_tm1638_asserts #(
    .HALF_DIV    (HALF_DIV),
    .FRAME_SCLKS (FRAME_SCLKS)
) u_asserts (.*);

// ==== tm1638_drv.sv ====
// ##############################################
// TM1638 LED and key board driver, top level
// connect dio_o/dio_oe_o/dio_i to one tristate pad
// ##############################################

`timescale 1ns/1ns

module tm1638_drv #(
    parameter int HALF_DIV    = tm1638_pkg::DEF_HALF_DIV,
    parameter int FRAME_SCLKS = tm1638_pkg::DEF_FRAME_SCLKS
) (
    input  logic        clk,
    input  logic        n_rst,
    input  logic [31:0] digits_i,
    input  logic [7:0]  blank_i,
    input  logic [7:0]  dots_i,
    input  logic [7:0]  leds_i,
    input  logic        dio_i,
    output logic        dio_o,
    output logic        dio_oe_o,
    output logic        sclk_o,
    output logic        stb_o,
    output logic        frame_start_o,
    output logic [7:0]  keys_o
);

    logic       fall_tick;
    logic       rise_tick;
    logic       frame_tick;
    logic [3:0] byte_idx;
    logic [7:0] grid_byte;

    byte_link_if link ();

    assign frame_start_o = frame_tick;

    sclk_divider #(
        .HALF_DIV    (HALF_DIV),
        .FRAME_SCLKS (FRAME_SCLKS)
    ) u_sclk_divider (
        .clk          (clk),
        .n_rst        (n_rst),
        .fall_tick_o  (fall_tick),
        .rise_tick_o  (rise_tick),
        .frame_tick_o (frame_tick)
    );

    display_buffer u_display_buffer (
        .clk          (clk),
        .n_rst        (n_rst),
        .frame_tick_i (frame_tick),
        .digits_i     (digits_i),
        .blank_i      (blank_i),
        .dots_i       (dots_i),
        .leds_i       (leds_i),
        .byte_idx_i   (byte_idx),
        .grid_byte_o  (grid_byte)
    );

    frame_sequencer u_frame_sequencer (
        .clk          (clk),
        .n_rst        (n_rst),
        .fall_tick_i  (fall_tick),
        .frame_tick_i (frame_tick),
        .link         (link.seq),
        .byte_idx_o   (byte_idx),
        .grid_byte_i  (grid_byte),
        .stb_o        (stb_o),
        .keys_o       (keys_o)
    );

    byte_shifter u_byte_shifter (
        .clk         (clk),
        .n_rst       (n_rst),
        .fall_tick_i (fall_tick),
        .rise_tick_i (rise_tick),
        .link        (link.shifter),
        .dio_i       (dio_i),
        .dio_o       (dio_o),
        .dio_oe_o    (dio_oe_o),
        .sclk_o      (sclk_o)
    );

endmodule

// ==== frame_sequencer.sv ====
// ##############################################
// one frame per frame tick: 40 | C0 + 16 grid
// bytes | 8F | 42 + 4 key bytes, each group in its
// own strobe low window, keys assembled at the end
// ##############################################

`timescale 1ns/1ns

module frame_sequencer (
    input  logic     clk,
    input  logic     n_rst,
    input  logic     fall_tick_i,
    input  logic     frame_tick_i,
    byte_link_if.seq link,
    output logic [3:0] byte_idx_o,
    input  logic [7:0] grid_byte_i,
    output logic     stb_o,
    output logic [7:0] keys_o
);

    tm1638_pkg::frame_state_e state_q;
    tm1638_pkg::frame_state_e gap_next_q;   // group after the strobe gap

    logic [3:0] grid_cnt_q;
    logic [1:0] key_cnt_q;
    logic [7:2] key_acc_q;
    logic       req_q;
    logic       link_idle;
    logic       byte_done;

    assign link_idle  = !req_q && !link.ack;
    assign byte_done  = req_q && link.ack;
    assign link.req    = req_q;
    assign link.dir_rd = (state_q == tm1638_pkg::FS_KEY_READ);
    assign byte_idx_o  = grid_cnt_q;

    always_comb begin
        case (state_q)
            tm1638_pkg::FS_WRITE_CMD: link.tx_byte = tm1638_pkg::CMD_WRITE_AUTO;
            tm1638_pkg::FS_ADDR_CMD:  link.tx_byte = tm1638_pkg::CMD_ADDR_0;
            tm1638_pkg::FS_GRID_DATA: link.tx_byte = grid_byte_i;
            tm1638_pkg::FS_DISP_CMD:  link.tx_byte = tm1638_pkg::CMD_DISPLAY_ON;
            tm1638_pkg::FS_READ_CMD:  link.tx_byte = tm1638_pkg::CMD_READ_KEYS;
            default:                  link.tx_byte = 8'h00;
        endcase
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            state_q    <= tm1638_pkg::FS_IDLE;
            gap_next_q <= tm1638_pkg::FS_IDLE;
            grid_cnt_q <= 4'd0;
            key_cnt_q  <= 2'd0;
            key_acc_q  <= '0;
            req_q      <= 1'b0;
            stb_o      <= 1'b1;
            keys_o     <= 8'h00;
        end else begin
            case (state_q)
                tm1638_pkg::FS_IDLE: begin
                    if (frame_tick_i) begin   // late ticks are dropped
                        state_q    <= tm1638_pkg::FS_WRITE_CMD;
                        grid_cnt_q <= 4'd0;
                        key_cnt_q  <= 2'd0;
                    end
                end
                tm1638_pkg::FS_STB_GAP: begin
                    if (fall_tick_i && link_idle) begin
                        stb_o   <= 1'b1;
                        state_q <= gap_next_q;
                    end
                end
                tm1638_pkg::FS_WRITE_CMD, tm1638_pkg::FS_ADDR_CMD,
                tm1638_pkg::FS_GRID_DATA, tm1638_pkg::FS_DISP_CMD,
                tm1638_pkg::FS_READ_CMD, tm1638_pkg::FS_KEY_READ: begin
                    if (stb_o) begin
                        if (fall_tick_i && link_idle) begin
                            stb_o <= 1'b0;   // open the group
                        end
                    end else if (link_idle) begin
                        req_q <= 1'b1;
                    end else if (byte_done) begin
                        req_q <= 1'b0;
                        case (state_q)
                            tm1638_pkg::FS_WRITE_CMD: begin
                                state_q    <= tm1638_pkg::FS_STB_GAP;
                                gap_next_q <= tm1638_pkg::FS_ADDR_CMD;
                            end
                            tm1638_pkg::FS_ADDR_CMD: begin
                                state_q <= tm1638_pkg::FS_GRID_DATA;
                            end
                            tm1638_pkg::FS_GRID_DATA: begin
                                if (grid_cnt_q == 4'(2 * tm1638_pkg::NUM_GRIDS - 1)) begin
                                    state_q    <= tm1638_pkg::FS_STB_GAP;
                                    gap_next_q <= tm1638_pkg::FS_DISP_CMD;
                                end else begin
                                    grid_cnt_q <= grid_cnt_q + 1'b1;
                                end
                            end
                            tm1638_pkg::FS_DISP_CMD: begin
                                state_q    <= tm1638_pkg::FS_STB_GAP;
                                gap_next_q <= tm1638_pkg::FS_READ_CMD;
                            end
                            tm1638_pkg::FS_READ_CMD: begin
                                state_q <= tm1638_pkg::FS_KEY_READ;
                            end
                            default: begin   // key byte k: bit0, bit4
                                if (key_cnt_q == 2'(tm1638_pkg::KEY_BYTES - 1)) begin
                                    keys_o     <= {key_acc_q, link.rx_byte[0], link.rx_byte[4]};
                                    state_q    <= tm1638_pkg::FS_STB_GAP;
                                    gap_next_q <= tm1638_pkg::FS_IDLE;
                                end else begin
                                    key_acc_q[7 - 2 * key_cnt_q] <= link.rx_byte[0];
                                    key_acc_q[6 - 2 * key_cnt_q] <= link.rx_byte[4];
                                    key_cnt_q <= key_cnt_q + 1'b1;
                                end
                            end
                        endcase
                    end
                end
                default: begin
                    state_q <= tm1638_pkg::FS_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== byte_shifter.sv ====
// ##############################################
// moves one byte over the serial link per req,
// LSB first, writes on dio_o or samples dio_i
// answers with ack once the 8th rise is done
// ##############################################

`timescale 1ns/1ns

module byte_shifter (
    input  logic         clk,
    input  logic         n_rst,
    input  logic         fall_tick_i,
    input  logic         rise_tick_i,
    byte_link_if.shifter link,
    input  logic         dio_i,
    output logic         dio_o,
    output logic         dio_oe_o,
    output logic         sclk_o
);

    tm1638_pkg::shift_state_e state_q;

    logic [2:0] bit_cnt_q;
    logic [7:0] shreg_q;
    logic       accept;
    logic       rise_step;   // sclk goes back high, one bit done

    assign accept    = (state_q == tm1638_pkg::SH_IDLE) && link.req;
    assign rise_step = (state_q == tm1638_pkg::SH_SHIFT) && rise_tick_i && !sclk_o;

    assign link.ack     = (state_q == tm1638_pkg::SH_DONE);
    assign link.rx_byte = shreg_q;

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            state_q   <= tm1638_pkg::SH_IDLE;
            bit_cnt_q <= 3'd0;
            sclk_o    <= 1'b1;
            dio_o     <= 1'b0;
            dio_oe_o  <= 1'b0;
        end else begin
            case (state_q)
                tm1638_pkg::SH_IDLE: begin
                    if (link.req) begin
                        state_q   <= tm1638_pkg::SH_SHIFT;
                        bit_cnt_q <= 3'd0;
                        dio_oe_o  <= !link.dir_rd;
                    end
                end
                tm1638_pkg::SH_SHIFT: begin
                    if (fall_tick_i) begin
                        sclk_o <= 1'b0;
                        dio_o  <= shreg_q[0];   // next bit out
                    end else if (rise_step) begin
                        sclk_o    <= 1'b1;
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                        if (bit_cnt_q == 3'd7) begin
                            state_q  <= tm1638_pkg::SH_DONE;
                            dio_oe_o <= 1'b0;   // release the line
                        end
                    end
                end
                tm1638_pkg::SH_DONE: begin
                    if (!link.req) begin
                        state_q <= tm1638_pkg::SH_IDLE;
                    end
                end
                default: begin
                    state_q <= tm1638_pkg::SH_IDLE;
                end
            endcase
        end
    end

    // shifts right on every rise, read bits enter at the top
    always_ff @(posedge clk) begin
        if (accept) begin
            shreg_q <= link.tx_byte;
        end else if (rise_step) begin
            shreg_q <= {dio_i, shreg_q[7:1]};
        end
    end

endmodule

// ==== display_buffer.sv ====
// ##############################################
// holds the display inputs for one frame and
// serves the 16 grid bytes by index
// even index: segments and dot, odd index: led
// ##############################################

`timescale 1ns/1ns

module display_buffer (
    input  logic        clk,
    input  logic        n_rst,
    input  logic        frame_tick_i,
    input  logic [31:0] digits_i,
    input  logic [7:0]  blank_i,
    input  logic [7:0]  dots_i,
    input  logic [7:0]  leds_i,
    input  logic [3:0]  byte_idx_i,
    output logic [7:0]  grid_byte_o
);

    logic [31:0]                      digits_q;
    logic [tm1638_pkg::NUM_GRIDS-1:0] blank_q;
    logic [tm1638_pkg::NUM_GRIDS-1:0] dots_q;
    logic [tm1638_pkg::NUM_GRIDS-1:0] leds_q;

    logic [2:0] grid;
    logic [3:0] digit;
    logic [6:0] seg_bits;

    assign grid  = byte_idx_i[3:1];
    assign digit = digits_q[{grid, 2'b00} +: 4];

    always_comb begin
        if (blank_q[grid]) begin
            seg_bits = 7'b0;
        end else begin
            seg_bits = tm1638_pkg::seg_code(digit);
        end
    end

    // snapshot at frame start, stable for the whole frame
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            digits_q <= '0;
            blank_q  <= '1;   // blanked until the first frame
            dots_q   <= '0;
            leds_q   <= '0;
        end else if (frame_tick_i) begin
            digits_q <= digits_i;
            blank_q  <= blank_i;
            dots_q   <= dots_i;
            leds_q   <= leds_i;
        end
    end

    // registered read
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            grid_byte_o <= 8'h00;
        end else if (byte_idx_i[0]) begin
            grid_byte_o <= {7'b0, leds_q[grid]};
        end else begin
            grid_byte_o <= {dots_q[grid], seg_bits};
        end
    end

endmodule

// ==== sclk_divider.sv ====
// ##############################################
// serial clock phase ticks and the frame tick
// fall and rise ticks alternate HALF_DIV clk apart,
// frame tick every FRAME_SCLKS serial periods
// ##############################################

`timescale 1ns/1ns

module sclk_divider #(
    parameter int HALF_DIV    = tm1638_pkg::DEF_HALF_DIV,
    parameter int FRAME_SCLKS = tm1638_pkg::DEF_FRAME_SCLKS
) (
    input  logic clk,
    input  logic n_rst,
    output logic fall_tick_o,
    output logic rise_tick_o,
    output logic frame_tick_o
);

    localparam int HALF_W  = (HALF_DIV > 1) ? $clog2(HALF_DIV) : 1;
    localparam int FRAME_W = (FRAME_SCLKS > 1) ? $clog2(FRAME_SCLKS) : 1;

    logic [HALF_W-1:0]  half_cnt_q;
    logic [FRAME_W-1:0] frame_cnt_q;
    logic               phase_q;     // 0: next tick is a fall
    logic               half_wrap;
    logic               frame_wrap;

    assign half_wrap  = (half_cnt_q == HALF_W'(HALF_DIV - 1));
    assign frame_wrap = (frame_cnt_q == FRAME_W'(FRAME_SCLKS - 1));

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            half_cnt_q  <= '0;
            phase_q     <= 1'b0;
            fall_tick_o <= 1'b0;
            rise_tick_o <= 1'b0;
        end else begin
            fall_tick_o <= half_wrap & ~phase_q;
            rise_tick_o <= half_wrap & phase_q;
            if (half_wrap) begin
                half_cnt_q <= '0;
                phase_q    <= ~phase_q;
            end else begin
                half_cnt_q <= half_cnt_q + 1'b1;
            end
        end
    end

    // counts rise ticks, one per serial period
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            frame_cnt_q  <= '0;
            frame_tick_o <= 1'b0;
        end else begin
            frame_tick_o <= half_wrap & phase_q & frame_wrap;
            if (half_wrap && phase_q) begin
                frame_cnt_q <= frame_wrap ? '0 : frame_cnt_q + 1'b1;
            end
        end
    end

endmodule

// ==== byte_link_if.sv ====
// ##############################################
// four-phase req/ack link between the frame
// sequencer and the byte shifter
// ##############################################

`timescale 1ns/1ns

interface byte_link_if;

    logic       req;
    logic       dir_rd;   // 1: sample a byte from the board
    logic [7:0] tx_byte;
    logic       ack;
    logic [7:0] rx_byte;  // valid while ack is high

    modport seq (
        output req,
        output dir_rd,
        output tx_byte,
        input  ack,
        input  rx_byte
    );

    modport shifter (
        input  req,
        input  dir_rd,
        input  tx_byte,
        output ack,
        output rx_byte
    );

endinterface

// ==== tm1638_pkg.sv ====
// ##############################################
// shared constants, state types and the segment
// table of the TM1638 board driver
// ##############################################

package tm1638_pkg;

    localparam int NUM_GRIDS = 8;
    localparam int KEY_BYTES = 4;      // key scan bytes per frame

    localparam logic [7:0] CMD_WRITE_AUTO = 8'h40;  // write, auto increment
    localparam logic [7:0] CMD_ADDR_0     = 8'hC0;
    localparam logic [7:0] CMD_DISPLAY_ON = 8'h8F;  // display on, full brightness
    localparam logic [7:0] CMD_READ_KEYS  = 8'h42;

    localparam int DEF_HALF_DIV    = 24;   // 48 MHz clk -> 1 MHz sclk
    localparam int DEF_FRAME_SCLKS = 8000;

    typedef enum logic [7:0] {
        FS_IDLE,
        FS_WRITE_CMD,
        FS_ADDR_CMD,
        FS_GRID_DATA,
        FS_DISP_CMD,
        FS_READ_CMD,
        FS_KEY_READ,
        FS_STB_GAP
    } frame_state_e;

    typedef enum logic [7:0] {
        SH_IDLE,
        SH_SHIFT,
        SH_DONE
    } shift_state_e;

    // hex digit to gfedcba
    function automatic logic [6:0] seg_code(input logic [3:0] digit);
        case (digit)
            4'h0: seg_code = 7'b0111111;
            4'h1: seg_code = 7'b0000110;
            4'h2: seg_code = 7'b1011011;
            4'h3: seg_code = 7'b1001111;
            4'h4: seg_code = 7'b1100110;
            4'h5: seg_code = 7'b1101101;
            4'h6: seg_code = 7'b1111101;
            4'h7: seg_code = 7'b0100111;
            4'h8: seg_code = 7'b1111111;
            4'h9: seg_code = 7'b1101111;
            4'hA: seg_code = 7'b1110111;
            4'hB: seg_code = 7'b1111100;
            4'hC: seg_code = 7'b0111001;
            4'hD: seg_code = 7'b1011110;
            4'hE: seg_code = 7'b1111001;
            default: seg_code = 7'b1110001;  // F
        endcase
    endfunction

endpackage
